/* include/combiner_defines.svh */
//////////////////////////////
// Color combiner constants
// Channel widths, channel count and the
// pipeline depths of the combiner stage
//////////////////////////////

`ifndef COMBINER_DEFINES_SVH
`define COMBINER_DEFINES_SVH

// Unsigned bits per color channel
`define COMBINER_CHANNEL_WIDTH 8

// Signed operand bits per channel, one sign bit on top of a channel
`define COMBINER_SIGNED_WIDTH 9

// Channels per pixel, R in the low bits, then G, B, A
`define COMBINER_CHANNELS 4

// Enabled cycles through the signed mixer
`define COMBINER_MIXER_DEPTH 2

// Enabled cycles from input to output
// Operand stage, mixer, resolve stage
`define COMBINER_LATENCY 4

`endif

/* hdl/combinerPkg.sv */
//////////////////////////////
// Color combiner types
// Pixel formats and configuration
// encodings of the combiner stage
//////////////////////////////

`include "combiner_defines.svh"

package combinerPkg;

    // One unsigned color channel
    typedef logic [`COMBINER_CHANNEL_WIDTH-1:0] channel_t;

    // RGBA pixel, index 0 is R
    typedef channel_t [`COMBINER_CHANNELS-1:0] pixel_t;

    // Signed channel, elements of a signedPixel_t keep their sign
    typedef logic signed [`COMBINER_SIGNED_WIDTH-1:0] signedChannel_t;

    // Mixer operand and result format
    typedef signedChannel_t [`COMBINER_CHANNELS-1:0] signedPixel_t;

    // Source of one mixer operand
    typedef enum logic [1:0] {
        srcPrimary  = 2'd0,
        srcTexture  = 2'd1,
        srcConstant = 2'd2,
        srcZero     = 2'd3
    } colorSrc_e;

    // Modifier applied to the selected source
    typedef enum logic [1:0] {
        modAsIs     = 2'd0,
        modOneMinus = 2'd1,
        modNegate   = 2'd2
    } operandMod_e;

    // Output scale before the final clamp
    typedef enum logic [1:0] {
        scale1x = 2'd0,
        scale2x = 2'd1,
        scale4x = 2'd2
    } combineScale_e;

endpackage

/* hdl/operandStage.sv */
//////////////////////////////
// Combiner operand stage
// Selects and modifies the four signed
// mixer operands, one register stage
//////////////////////////////

`timescale 1ns/10ps

`include "combiner_defines.svh"

module operandStage (
    input  logic                      aclk,
    input  logic                      arstN,
    input  logic                      ce,
    input  logic                      validIn,

    input  combinerPkg::pixel_t       primaryColor,
    input  combinerPkg::pixel_t       textureColor,
    input  combinerPkg::pixel_t       constColor,

    input  combinerPkg::colorSrc_e    srcA,
    input  combinerPkg::colorSrc_e    srcB,
    input  combinerPkg::colorSrc_e    srcC,
    input  combinerPkg::colorSrc_e    srcD,

    input  combinerPkg::operandMod_e  modA,
    input  combinerPkg::operandMod_e  modB,
    input  combinerPkg::operandMod_e  modC,
    input  combinerPkg::operandMod_e  modD,

    output combinerPkg::signedPixel_t operandA,
    output combinerPkg::signedPixel_t operandB,
    output combinerPkg::signedPixel_t operandC,
    output combinerPkg::signedPixel_t operandD,
    output logic                      operandValid
);

    // 1.0 in the unsigned channel format
    localparam logic signed [`COMBINER_SIGNED_WIDTH-1:0] ONE_DOT_ZERO =
        (1 <<< `COMBINER_CHANNEL_WIDTH) - 1;

    // Forms one signed operand pixel from its source and modifier
    function automatic combinerPkg::signedPixel_t formOperand(
        input combinerPkg::colorSrc_e   src,
        input combinerPkg::operandMod_e mod,
        input combinerPkg::pixel_t      primary,
        input combinerPkg::pixel_t      texture,
        input combinerPkg::pixel_t      constant
    );
        combinerPkg::pixel_t         selected;
        combinerPkg::signedChannel_t extended;
        combinerPkg::signedPixel_t   result;

        case (src)
            combinerPkg::srcPrimary:  selected = primary;
            combinerPkg::srcTexture:  selected = texture;
            combinerPkg::srcConstant: selected = constant;
            default:                  selected = '0;
        endcase

        for (int i = 0; i < `COMBINER_CHANNELS; i++) begin
            // Zero extension keeps the channel positive
            extended = {1'b0, selected[i]};
            case (mod)
                combinerPkg::modOneMinus: result[i] = ONE_DOT_ZERO - extended;
                combinerPkg::modNegate:   result[i] = -extended;
                default:                  result[i] = extended;
            endcase
        end
        return result;
    endfunction

    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            operandValid <= 1'b0;
        end else if (ce) begin
            operandValid <= validIn;
        end
    end

    always_ff @(posedge aclk) begin
        if (ce) begin
            operandA <= formOperand(srcA, modA, primaryColor, textureColor, constColor);
            operandB <= formOperand(srcB, modB, primaryColor, textureColor, constColor);
            operandC <= formOperand(srcC, modC, primaryColor, textureColor, constColor);
            operandD <= formOperand(srcD, modD, primaryColor, textureColor, constColor);
        end
    end

endmodule

/* hdl/colorMixerSigned.sv */
//////////////////////////////
// Signed color mixer
// mixedColor = A * B + C * D per channel,
// rounded by 1.0 = 255, shifted and
// saturated to signed 9 bits, 2 cycles
//////////////////////////////

`timescale 1ns/10ps

`include "combiner_defines.svh"

module colorMixerSigned (
    input  logic                      aclk,
    input  logic                      ce,

    input  combinerPkg::signedPixel_t colorA,
    input  combinerPkg::signedPixel_t colorB,
    input  combinerPkg::signedPixel_t colorC,
    input  combinerPkg::signedPixel_t colorD,

    output combinerPkg::signedPixel_t mixedColor
);

    // Full signed product of two operands
    localparam int PRODUCT_WIDTH = 2 * `COMBINER_SIGNED_WIDTH;

    // One extra bit for the carry of the pair sum
    localparam int SUM_WIDTH = PRODUCT_WIDTH + 1;

    // Fixed point position, 1.0 is 255
    localparam int FRACTION_BITS = `COMBINER_CHANNEL_WIDTH;

    localparam logic signed [SUM_WIDTH-1:0] ONE_DOT_ZERO = (1 <<< FRACTION_BITS) - 1;

    // Limits of the signed channel
    localparam logic signed [SUM_WIDTH-1:0] SAT_MAX = (1 <<< (`COMBINER_SIGNED_WIDTH - 1)) - 1;
    localparam logic signed [SUM_WIDTH-1:0] SAT_MIN = -(1 <<< (`COMBINER_SIGNED_WIDTH - 1));

    logic signed [PRODUCT_WIDTH-1:0] productAB [`COMBINER_CHANNELS];
    logic signed [PRODUCT_WIDTH-1:0] productCD [`COMBINER_CHANNELS];

    logic signed [SUM_WIDTH-1:0] pairSum [`COMBINER_CHANNELS];
    logic signed [SUM_WIDTH-1:0] rounded [`COMBINER_CHANNELS];

    function automatic combinerPkg::signedChannel_t saturate(
        input logic signed [SUM_WIDTH-1:0] value
    );
        combinerPkg::signedChannel_t result;

        if (value > SAT_MAX) begin
            result = SAT_MAX[`COMBINER_SIGNED_WIDTH-1:0];
        end else if (value < SAT_MIN) begin
            result = SAT_MIN[`COMBINER_SIGNED_WIDTH-1:0];
        end else begin
            result = value[`COMBINER_SIGNED_WIDTH-1:0];
        end
        return result;
    endfunction

    // First cycle registers the eight products
    always_ff @(posedge aclk) begin
        if (ce) begin
            for (int i = 0; i < `COMBINER_CHANNELS; i++) begin
                productAB[i] <= colorA[i] * colorB[i];
                productCD[i] <= colorC[i] * colorD[i];
            end
        end
    end

    // Pair sum with rounding constant, arithmetic shift keeps the sign
    always_comb begin
        for (int i = 0; i < `COMBINER_CHANNELS; i++) begin
            pairSum[i] = productAB[i] + productCD[i] + ONE_DOT_ZERO;
            rounded[i] = pairSum[i] >>> FRACTION_BITS;
        end
    end

    // Second cycle registers the saturated result
    always_ff @(posedge aclk) begin
        if (ce) begin
            for (int i = 0; i < `COMBINER_CHANNELS; i++) begin
                mixedColor[i] <= saturate(rounded[i]);
            end
        end
    end

endmodule

/* hdl/combinerResolve.sv */
//////////////////////////////
// Combiner resolve stage
// Aligns valid and scale with the mixer,
// scales and clamps to an unsigned pixel
//////////////////////////////

`timescale 1ns/10ps

`include "combiner_defines.svh"

module combinerResolve (
    input  logic                       aclk,
    input  logic                       arstN,
    input  logic                       ce,
    input  logic                       validIn,

    input  combinerPkg::signedPixel_t  mixedColor,
    input  combinerPkg::combineScale_e scale,

    output logic                       validOut,
    output combinerPkg::pixel_t        pixelOut
);

    // Two guard bits for the 4x shift
    localparam int SCALED_WIDTH = `COMBINER_SIGNED_WIDTH + 2;

    localparam logic signed [SCALED_WIDTH-1:0] CHANNEL_MAX = (1 <<< `COMBINER_CHANNEL_WIDTH) - 1;

    // Scale arrives unregistered, one stage ahead of validIn
    localparam int SCALE_DEPTH = `COMBINER_MIXER_DEPTH + 1;

    logic [`COMBINER_MIXER_DEPTH-1:0] validPipe;
    combinerPkg::combineScale_e       scalePipe [SCALE_DEPTH];
    combinerPkg::pixel_t              clamped;

    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            validPipe <= '0;
        end else if (ce) begin
            validPipe <= {validPipe[`COMBINER_MIXER_DEPTH-2:0], validIn};
        end
    end

    always_ff @(posedge aclk) begin
        if (ce) begin
            scalePipe[0] <= scale;
            for (int i = 1; i < SCALE_DEPTH; i++) begin
                scalePipe[i] <= scalePipe[i-1];
            end
        end
    end

    always_comb begin
        logic signed [SCALED_WIDTH-1:0] scaled;

        for (int i = 0; i < `COMBINER_CHANNELS; i++) begin
            // Sign extension before the shift
            scaled = mixedColor[i];
            case (scalePipe[SCALE_DEPTH-1])
                combinerPkg::scale2x: scaled = scaled <<< 1;
                combinerPkg::scale4x: scaled = scaled <<< 2;
                default:              scaled = scaled;
            endcase

            if (scaled < 0) begin
                clamped[i] = '0;
            end else if (scaled > CHANNEL_MAX) begin
                clamped[i] = CHANNEL_MAX[`COMBINER_CHANNEL_WIDTH-1:0];
            end else begin
                clamped[i] = scaled[`COMBINER_CHANNEL_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            validOut <= 1'b0;
            pixelOut <= '0;
        end else if (ce) begin
            validOut <= validPipe[`COMBINER_MIXER_DEPTH-1];
            pixelOut <= clamped;
        end
    end

endmodule

/* hdl/colorCombiner.sv */
//////////////////////////////
// Color combiner top level
// Operand stage, signed mixer and
// resolve stage of the texture environment
//////////////////////////////

`timescale 1ns/10ps

module colorCombiner (
    input  logic                       aclk,
    input  logic                       arstN,
    input  logic                       ce,
    input  logic                       validIn,

    input  combinerPkg::pixel_t        primaryColor,
    input  combinerPkg::pixel_t        textureColor,
    input  combinerPkg::pixel_t        constColor,

    input  combinerPkg::colorSrc_e     srcA,
    input  combinerPkg::colorSrc_e     srcB,
    input  combinerPkg::colorSrc_e     srcC,
    input  combinerPkg::colorSrc_e     srcD,

    input  combinerPkg::operandMod_e   modA,
    input  combinerPkg::operandMod_e   modB,
    input  combinerPkg::operandMod_e   modC,
    input  combinerPkg::operandMod_e   modD,

    input  combinerPkg::combineScale_e scale,

    output logic                       validOut,
    output combinerPkg::pixel_t        pixelOut
);

    combinerPkg::signedPixel_t operandA;
    combinerPkg::signedPixel_t operandB;
    combinerPkg::signedPixel_t operandC;
    combinerPkg::signedPixel_t operandD;
    combinerPkg::signedPixel_t mixedColor;
    logic                      operandValid;

    operandStage operandStage_i (
        .aclk         (aclk),
        .arstN        (arstN),
        .ce           (ce),
        .validIn      (validIn),
        .primaryColor (primaryColor),
        .textureColor (textureColor),
        .constColor   (constColor),
        .srcA         (srcA),
        .srcB         (srcB),
        .srcC         (srcC),
        .srcD         (srcD),
        .modA         (modA),
        .modB         (modB),
        .modC         (modC),
        .modD         (modD),
        .operandA     (operandA),
        .operandB     (operandB),
        .operandC     (operandC),
        .operandD     (operandD),
        .operandValid (operandValid)
    );

    colorMixerSigned colorMixerSigned_i (
        .aclk       (aclk),
        .ce         (ce),
        .colorA     (operandA),
        .colorB     (operandB),
        .colorC     (operandC),
        .colorD     (operandD),
        .mixedColor (mixedColor)
    );

    // Valid bypasses the mixer and is realigned in the resolve stage
    combinerResolve combinerResolve_i (
        .aclk       (aclk),
        .arstN      (arstN),
        .ce         (ce),
        .validIn    (operandValid),
        .mixedColor (mixedColor),
        .scale      (scale),
        .validOut   (validOut),
        .pixelOut   (pixelOut)
    );

endmodule

/* verification/colorCombiner_properties.sv */
//////////////////////////////
// Combiner output checks
// Reset, stall and valid behavior
// at the combiner outputs
//////////////////////////////

`timescale 1ns/10ps

module colorCombinerProperties (
    input logic                aclk,
    input logic                arstN,
    input logic                ce,
    input logic                validOut,
    input combinerPkg::pixel_t pixelOut
);

    // No output strobe while the pipeline is held in reset
    resetQuiet: assert property (@(posedge aclk) !arstN |-> !validOut)
        else $error("validOut is high during reset");

    // A stalled edge holds both outputs
    stallHolds: assert property (@(posedge aclk) disable iff (!arstN)
        !ce |=> $stable(pixelOut) && $stable(validOut))
        else $error("Outputs changed across an edge with ce low");

    // The strobe moves only on an enabled edge
    validEnabled: assert property (@(posedge aclk) disable iff (!arstN)
        (validOut != $past(validOut)) |-> $past(ce))
        else $error("validOut changed on an edge with ce low");

endmodule

bind colorCombiner colorCombinerProperties colorCombinerProperties_i (
    .aclk     (aclk),
    .arstN    (arstN),
    .ce       (ce),
    .validOut (validOut),
    .pixelOut (pixelOut)
);

/* verification/colorCombinerTb.sv */
//////////////////////////////
// Color combiner testbench
// Replays the cases file through the
// combiner under ce stalls and checks
// pixels, latency and strobe count
//////////////////////////////

`timescale 1ns/10ps

`include "combiner_defines.svh"

module colorCombinerTb;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CASES = 64;
    localparam int CASE_BITS = 172;

    logic aclk, arstN, ce, validIn, validOut;
    combinerPkg::pixel_t primaryColor, textureColor, constColor, pixelOut;
    combinerPkg::colorSrc_e srcA, srcB, srcC, srcD;
    combinerPkg::operandMod_e modA, modB, modC, modD;
    combinerPkg::combineScale_e scale;

    // Group, selects, modifiers, scale, stall, three colors, expected pixel
    logic [CASE_BITS-1:0] caseMem [MAX_CASES];

    combinerPkg::pixel_t expectQ [$];
    string               nameQ [$];
    int                  entryQ [$];

    int seed = 32'h227acd1a;
    int caseCount, longestStall, timeLimit;
    int inputCount, outputCount, edgeCount;
    bit casesLoaded, lastEdgeEnabled;

    colorCombiner colorCombiner_i (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic checkPixel(input string name, input combinerPkg::pixel_t expected,
                              input combinerPkg::pixel_t actual);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkValid(input string name, input int expected, input int actual);
        if (actual != expected) begin
            failRun($sformatf("Mismatch in %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic checkLatency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            failRun($sformatf("Mismatch in %s latency: expected %0d, actual %0d",
                              name, expected, actual));
        end
    endtask

    function automatic string caseGroupName(input logic [3:0] group);
        case (group)
            4'd1:    return "modulate";
            4'd2:    return "interpolate";
            4'd3:    return "subtract";
            4'd4:    return "scale";
            default: return "stall";
        endcase
    endfunction

    // A zero group marks the end of the table
    task automatic loadCases();
        for (int i = 0; i < MAX_CASES; i++) begin
            caseMem[i] = '0;
        end
        $readmemh("verification/combiner_cases.txt", caseMem);
        caseCount = 0;
        longestStall = 0;
        while (caseCount < MAX_CASES && caseMem[caseCount][171:168] != 4'h0) begin
            if (int'(caseMem[caseCount][131:128]) > longestStall) begin
                longestStall = int'(caseMem[caseCount][131:128]);
            end
            caseCount++;
        end
    endtask

    task automatic presentFragment(input int idx);
        logic [CASE_BITS-1:0] word;
        int maxStall;
        int stallCycles;

        word = caseMem[idx];
        maxStall = int'(word[131:128]);
        stallCycles = 0;
        if (maxStall > 0) begin
            stallCycles = int'($unsigned($random(seed)) % (maxStall + 1));
        end
        repeat (stallCycles) begin
            @(negedge aclk);
            ce = 1'b0;
        end
        @(negedge aclk);
        ce = 1'b1;
        validIn = 1'b1;
        srcA = combinerPkg::colorSrc_e'(word[165:164]);
        srcB = combinerPkg::colorSrc_e'(word[161:160]);
        srcC = combinerPkg::colorSrc_e'(word[157:156]);
        srcD = combinerPkg::colorSrc_e'(word[153:152]);
        modA = combinerPkg::operandMod_e'(word[149:148]);
        modB = combinerPkg::operandMod_e'(word[145:144]);
        modC = combinerPkg::operandMod_e'(word[141:140]);
        modD = combinerPkg::operandMod_e'(word[137:136]);
        scale = combinerPkg::combineScale_e'(word[133:132]);
        primaryColor = word[127:96];
        textureColor = word[95:64];
        constColor = word[63:32];
        expectQ.push_back(word[31:0]);
        nameQ.push_back($sformatf("%s_%0d", caseGroupName(word[171:168]), idx));
        inputCount++;
    endtask

    // Counts enabled edges and the edge on which each fragment enters
    always @(posedge aclk) begin
        lastEdgeEnabled = ce;
        if (ce && arstN) begin
            edgeCount++;
            if (validIn) begin
                entryQ.push_back(edgeCount);
            end
        end
    end

    always @(negedge aclk) begin
        string name;
        combinerPkg::pixel_t expected;
        int entryEdge;

        if (!arstN) begin
            if (validOut !== 1'b0) begin
                failRun("validOut is high while reset is asserted");
            end
        end else if (lastEdgeEnabled && validOut === 1'b1) begin
            outputCount++;
            // A strobe with nothing in flight only shows up in the pulse count
            if (expectQ.size() != 0) begin
                name = nameQ.pop_front();
                expected = expectQ.pop_front();
                entryEdge = entryQ.pop_front();
                checkPixel(name, expected, pixelOut);
                checkLatency(name, `COMBINER_LATENCY, edgeCount - entryEdge + 1);
            end
        end
    end

    initial begin
        wait (casesLoaded);
        #(timeLimit);
        failRun($sformatf("Timeout: the run did not finish within %0d ns", timeLimit));
    end

    initial begin
        arstN = 1'b0;
        ce = 1'b1;
        validIn = 1'b0;
        primaryColor = '0;
        textureColor = '0;
        constColor = '0;
        srcA = combinerPkg::srcZero;
        srcB = combinerPkg::srcZero;
        srcC = combinerPkg::srcZero;
        srcD = combinerPkg::srcZero;
        modA = combinerPkg::modAsIs;
        modB = combinerPkg::modAsIs;
        modC = combinerPkg::modAsIs;
        modD = combinerPkg::modAsIs;
        scale = combinerPkg::scale1x;

        loadCases();
        if (caseCount == 0) begin
            failRun("No cases were read from the cases file");
        end
        timeLimit = (caseCount * (`COMBINER_LATENCY + longestStall) + RESET_CYCLES + 40)
                    * CLK_PERIOD;
        casesLoaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge aclk);
        arstN = 1'b1;
        // Idle cycles, nothing may come out yet
        repeat (3) @(negedge aclk);

        for (int i = 0; i < caseCount; i++) begin
            presentFragment(i);
        end
        @(negedge aclk);
        validIn = 1'b0;
        ce = 1'b1;

        while (expectQ.size() != 0) @(negedge aclk);
        // Extra cycles catch duplicated strobes
        repeat (`COMBINER_LATENCY + 2) @(negedge aclk);
        checkValid("validOut pulse count", inputCount, outputCount);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verification/combiner_cases.txt */
// group_srcABCD_modABCD_scale_maxStall_primary_texture_constant_expected, colors as AABBGGRR
// group 1 modulate, 2 interpolate, 3 subtract, 4 scale, 5 stall; src 0 P 1 T 2 K 3 zero
// mod 0 as-is 1 one-minus 2 negate; scale 0 1x 1 2x 2 4x; maxStall is the longest ce-low run
1_0133_0000_0_0_FFFFFFFF_12345678_00000000_12345678
1_0133_0000_0_0_80808080_80808080_00000000_40404040
1_0133_0000_0_0_FF804020_10C0FF64_00000000_1060400D
1_1333_0100_0_0_11223344_DEADBEEF_55667788_DEADBEEF
1_2333_0100_0_0_11223344_DEADBEEF_00FF7F01_00FF7F01
1_0313_0101_0_0_30201008_40302010_00000000_70503018
2_1202_0001_0_0_C0804020_FFFFFFFF_00000000_C0804020
2_1202_0001_0_0_01020304_89ABCDEF_FFFFFFFF_89ABCDEF
2_1202_0001_0_0_00000000_FFFFFFFF_80808080_80808080
2_1202_0001_0_0_9920FF00_338000FF_FFC08040_33687F40
3_0313_0121_0_0_00FF8010_FF003020_00000000_00FF5000
3_0133_2000_0_0_FF00A050_80FF0040_00000000_00000000
3_0123_2221_0_0_FF8000FF_FF80FFFF_FF40FF00_000100FF
3_0313_0101_0_0_1080C0F0_208060A0_00000000_30FFFFFF
3_0313_2121_0_0_FFFFFFFF_FFFFFFFF_00000000_00000000
4_0313_0101_1_0_10204060_0010501F_00000000_2060FFFE
4_0133_0000_2_0_FFFFFFFF_403F2008_00000000_FFFC8020
4_0313_0121_2_0_00000020_02020200_00000000_00000080
4_1202_0001_1_0_7F80003A_12345678_00000000_FEFF0074
5_0133_0000_0_7_FFFFFFFF_0A141E28_00000000_0A141E28
5_0313_0101_0_7_01020304_10203040_00000000_11223344
5_1333_0100_0_7_00000000_CAFEF00D_00000000_CAFEF00D
5_0133_0000_0_7_80808080_80808080_00000000_40404040
5_1202_0001_0_7_00112233_5A5AA5A5_FFFFFFFF_5A5AA5A5
5_0313_0121_0_7_FFFFFFFF_00000000_00000000_FFFFFFFF
5_0313_0101_1_7_01020304_01020304_00000000_04080C10
5_0133_0000_0_7_FF804020_10C0FF64_00000000_1060400D

/* all.f */
+incdir+include
hdl/combinerPkg.sv
hdl/operandStage.sv
hdl/colorMixerSigned.sv
hdl/combinerResolve.sv
hdl/colorCombiner.sv
verification/colorCombiner_properties.sv
verification/colorCombinerTb.sv

/* run.sh */
#!/bin/sh
# Builds the color combiner testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module colorCombinerTb --Mdir obj_dir -o colorCombinerSim

output=$(./obj_dir/colorCombinerSim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q -x -F '*** PASSED ***'; then
    exit 0
fi
exit 1
